/* design/sd_consts.svh */
// sd spi engine constants
// frame lengths, block size, request queue depth, crc polynomials and timeouts
`ifndef SD_CONSTS_SVH
`define SD_CONSTS_SVH

// start, transmit, index, argument, crc7, stop
`define SD_CMD_BITS 48
// crc7 plus stop bit at the end of a command frame
`define SD_CMD_TAIL_BITS 8
`define SD_BLOCK_BITS 4096
// token, block, crc16
`define SD_DATA_FRAME_BITS 4120
`define SD_CRC16_BITS 16
`define SD_START_TOKEN 8'hFE
`define SD_CRC7_POLY 7'h09
`define SD_CRC16_POLY 16'h1021

// queue slots, also the host credits after reset
`define SD_REQ_DEPTH 2
`define SD_RESP_WAIT_BYTES 8
// in bit times
`define SD_BUSY_TIMEOUT 4096

`define SD_DIV_BITS 16
`define SD_DIV_RESET 16'd2

`endif

/* design/sd_cmd_pkg.sv */
// command side types of the sd spi engine
// request opcode, command fields and the response byte

package sd_cmd_pkg;

  // what a queued request asks the engine to do
  typedef enum logic {
    REQ_CMD   = 1'b0,
    REQ_WRITE = 1'b1
  } req_kind_e;

  // six bit command index, CMD0..CMD63
  typedef logic [5:0] cmd_index_t;

  typedef logic [31:0] cmd_arg_t;

  // r1 response or data-response token, msb first on the wire
  typedef logic [7:0] r1_t;

endpackage

/* design/sd_ctrl_pkg.sv */
// control side types of the sd spi engine
// sequencer states and the completion status reported to the host

package sd_ctrl_pkg;

  typedef enum logic [2:0] {
    S_IDLE,
    // frame going out on mosi
    S_SEND,
    // waiting for the r1 byte
    S_RESP,
    // waiting for the data token and the end of busy
    S_BUSY,
    S_DONE
  } seq_state_e;

  typedef enum logic [1:0] {
    ST_OK,
    ST_RESP_TIMEOUT,
    ST_BUSY_TIMEOUT
  } done_status_e;

endpackage

/* design/sd_ctrl_regs.sv */
// sd engine register block
// holds the spi clock divider and a small request queue,
// returns one host credit for every slot the sequencer frees
`include "sd_consts.svh"

module sd_ctrl_regs (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      cfg_div_write,
  input  logic [`SD_DIV_BITS-1:0]   cfg_div_value,
  output logic [`SD_DIV_BITS-1:0]   cfg_div,
  input  logic                      req_valid,
  input  sd_cmd_pkg::req_kind_e     req_kind,
  input  sd_cmd_pkg::cmd_index_t    req_index,
  input  sd_cmd_pkg::cmd_arg_t      req_arg,
  input  logic [`SD_BLOCK_BITS-1:0] req_data,
  output logic                      head_valid,
  output sd_cmd_pkg::req_kind_e     head_kind,
  output sd_cmd_pkg::cmd_index_t    head_index,
  output sd_cmd_pkg::cmd_arg_t      head_arg,
  output logic [`SD_BLOCK_BITS-1:0] head_data,
  input  logic                      pop,
  output logic                      credit_return
);

  localparam int PTR_BITS = $clog2(`SD_REQ_DEPTH);
  localparam int CNT_BITS = $clog2(`SD_REQ_DEPTH + 1);

  sd_cmd_pkg::req_kind_e  kind_q  [`SD_REQ_DEPTH];
  sd_cmd_pkg::cmd_index_t index_q [`SD_REQ_DEPTH];
  sd_cmd_pkg::cmd_arg_t   arg_q   [`SD_REQ_DEPTH];
  logic [`SD_BLOCK_BITS-1:0] data_q [`SD_REQ_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic push;
  logic take;

  // a request without a credit is dropped once the queue is full
  assign push = req_valid && (count != CNT_BITS'(`SD_REQ_DEPTH));
  assign take = pop && head_valid;

  assign head_valid = (count != '0);
  assign head_kind  = kind_q[rd_ptr];
  assign head_index = index_q[rd_ptr];
  assign head_arg   = arg_q[rd_ptr];
  assign head_data  = data_q[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      cfg_div <= `SD_DIV_RESET;
    end else if (cfg_div_write) begin
      // a zero divider would stop the bit clock
      cfg_div <= (cfg_div_value == '0) ? `SD_DIV_BITS'(1) : cfg_div_value;
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      kind_q[wr_ptr]  <= req_kind;
      index_q[wr_ptr] <= req_index;
      arg_q[wr_ptr]   <= req_arg;
      data_q[wr_ptr]  <= req_data;
    end
  end

  // pointers wrap on their own, the depth is a power of two
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= take;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (take) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* design/sd_controller.sv */
// sd engine sequencer
// makes the bit tick and sclk from the divider, pops requests, loads the
// sender, arms the receiver and reports completion with status and response
`include "sd_consts.svh"

module sd_controller (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [`SD_DIV_BITS-1:0]    cfg_div,
  input  logic                       head_valid,
  input  sd_cmd_pkg::req_kind_e      head_kind,
  input  sd_cmd_pkg::cmd_index_t     head_index,
  input  sd_cmd_pkg::cmd_arg_t       head_arg,
  input  logic [`SD_BLOCK_BITS-1:0]  head_data,
  output logic                       pop,
  output logic                       load,
  output sd_cmd_pkg::req_kind_e      kind,
  output sd_cmd_pkg::cmd_index_t     index,
  output sd_cmd_pkg::cmd_arg_t       arg,
  output logic [`SD_BLOCK_BITS-1:0]  data,
  output logic                       bit_tick,
  output logic                       sclk,
  output logic                       cs_n,
  input  logic                       sending,
  output logic                       arm,
  output logic                       expect_data,
  input  logic                       rx_done,
  input  sd_cmd_pkg::r1_t            rx_byte,
  input  logic                       rx_timeout,
  input  logic                       busy_timeout,
  output logic                       done_valid,
  output sd_ctrl_pkg::done_status_e  done_status,
  output sd_cmd_pkg::r1_t            done_resp
);

  sd_ctrl_pkg::seq_state_e state;
  logic [`SD_DIV_BITS-1:0] div_cnt;
  logic sending_q;
  logic start;

  // last cycle of each bit period; >= copes with a divider lowered mid count
  assign bit_tick = (div_cnt >= cfg_div - 1'b1);
  // low in the first half of the bit, high in the second, parked while deselected
  assign sclk = !cs_n && (div_cnt >= (cfg_div >> 1));

  assign start = (state == sd_ctrl_pkg::S_IDLE) && head_valid && bit_tick;
  assign pop   = start;
  assign load  = start;
  assign kind  = head_kind;
  assign index = head_index;
  assign arg   = head_arg;
  assign data  = head_data;

  // frame fully out, hand the line over to the receiver
  assign arm = (state == sd_ctrl_pkg::S_SEND) && sending_q && !sending;
  assign done_valid = (state == sd_ctrl_pkg::S_DONE);

  always_ff @(posedge clock) begin
    if (reset || bit_tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      sending_q <= 1'b0;
    end else begin
      sending_q <= sending;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= sd_ctrl_pkg::S_IDLE;
      cs_n        <= 1'b1;
      expect_data <= 1'b0;
      done_status <= sd_ctrl_pkg::ST_OK;
      done_resp   <= '0;
    end else begin
      case (state)
        sd_ctrl_pkg::S_IDLE: begin
          if (start) begin
            state       <= sd_ctrl_pkg::S_SEND;
            cs_n        <= 1'b0;
            expect_data <= (head_kind == sd_cmd_pkg::REQ_WRITE);
          end
        end
        sd_ctrl_pkg::S_SEND: begin
          if (arm) begin
            state <= expect_data ? sd_ctrl_pkg::S_BUSY : sd_ctrl_pkg::S_RESP;
          end
        end
        sd_ctrl_pkg::S_RESP, sd_ctrl_pkg::S_BUSY: begin
          if (rx_done) begin
            state     <= sd_ctrl_pkg::S_DONE;
            done_resp <= rx_byte;
            if (rx_timeout) begin
              done_status <= sd_ctrl_pkg::ST_RESP_TIMEOUT;
            end else if (busy_timeout) begin
              done_status <= sd_ctrl_pkg::ST_BUSY_TIMEOUT;
            end else begin
              done_status <= sd_ctrl_pkg::ST_OK;
            end
          end
        end
        sd_ctrl_pkg::S_DONE: begin
          state <= sd_ctrl_pkg::S_IDLE;
          cs_n  <= 1'b1;
        end
        default: state <= sd_ctrl_pkg::S_IDLE;
      endcase
    end
  end

endmodule

/* design/sd_sender.sv */
// sd spi frame sender
// shifts out a command frame with crc7 and stop bit, or a start token,
// one data block and crc16, one bit per bit tick, msb first
`include "sd_consts.svh"

module sd_sender (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      bit_tick,
  input  logic                      load,
  input  sd_cmd_pkg::req_kind_e     kind,
  input  sd_cmd_pkg::cmd_index_t    index,
  input  sd_cmd_pkg::cmd_arg_t      arg,
  input  logic [`SD_BLOCK_BITS-1:0] data,
  output logic                      mosi,
  output logic                      sending
);

  localparam int FRAME_MSB = `SD_DATA_FRAME_BITS - 1;
  localparam int CNT_BITS  = $clog2(`SD_DATA_FRAME_BITS + 1);
  // frame bits ahead of the crc7: start, transmit, index, argument
  localparam int CMD_HEAD_BITS = `SD_CMD_BITS - `SD_CMD_TAIL_BITS;

  logic [FRAME_MSB:0] shreg;
  logic [CNT_BITS-1:0] bit_cnt;
  sd_cmd_pkg::req_kind_e kind_q;
  logic [6:0] crc7;
  logic [15:0] crc16;
  logic is_data;
  logic crc_phase;
  logic crc_accum;
  logic out_bit;
  logic fb7;
  logic fb16;

  assign is_data = (kind_q == sd_cmd_pkg::REQ_WRITE);
  // high from the load cycle until the last bit has gone out
  assign sending = load || (bit_cnt != '0);

  // bit_cnt counts the bits still to go, so the frame position follows from it
  always_comb begin
    if (is_data) begin
      crc_phase = (bit_cnt <= CNT_BITS'(`SD_CRC16_BITS));
      // the token is not covered by the crc16
      crc_accum = !crc_phase &&
                  (bit_cnt <= CNT_BITS'(`SD_BLOCK_BITS + `SD_CRC16_BITS));
    end else begin
      // last bit is the stop bit, taken from the ones behind the argument
      crc_phase = (bit_cnt <= CNT_BITS'(`SD_CMD_TAIL_BITS)) && (bit_cnt > 1);
      crc_accum = (bit_cnt > CNT_BITS'(`SD_CMD_TAIL_BITS));
    end
  end

  assign out_bit = crc_phase ? (is_data ? crc16[15] : crc7[6]) : shreg[FRAME_MSB];
  assign fb7  = crc7[6] ^ out_bit;
  assign fb16 = crc16[15] ^ out_bit;

  always_ff @(posedge clock) begin
    if (reset) begin
      bit_cnt <= '0;
      mosi    <= 1'b1;
      kind_q  <= sd_cmd_pkg::REQ_CMD;
    end else if (load) begin
      kind_q  <= kind;
      bit_cnt <= (kind == sd_cmd_pkg::REQ_WRITE) ? CNT_BITS'(`SD_DATA_FRAME_BITS)
                                                  : CNT_BITS'(`SD_CMD_BITS);
    end else if (bit_tick) begin
      if (bit_cnt != '0) begin
        mosi    <= out_bit;
        bit_cnt <= bit_cnt - 1'b1;
      end else begin
        // back to idle high one bit after the frame
        mosi <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      crc7  <= '0;
      crc16 <= '0;
      if (kind == sd_cmd_pkg::REQ_WRITE) begin
        shreg <= {`SD_START_TOKEN, data, {`SD_CRC16_BITS{1'b1}}};
      end else begin
        shreg <= {1'b0, 1'b1, index, arg, {(`SD_DATA_FRAME_BITS - CMD_HEAD_BITS){1'b1}}};
      end
    end else if (bit_tick && (bit_cnt != '0)) begin
      shreg <= {shreg[FRAME_MSB-1:0], 1'b1};
      if (crc_phase) begin
        // remainder shifts out msb first
        crc7  <= {crc7[5:0], 1'b0};
        crc16 <= {crc16[14:0], 1'b0};
      end else if (crc_accum) begin
        crc7  <= {crc7[5:0], 1'b0} ^ (fb7 ? `SD_CRC7_POLY : 7'h00);
        crc16 <= {crc16[14:0], 1'b0} ^ (fb16 ? `SD_CRC16_POLY : 16'h0000);
      end
    end
  end

endmodule

/* design/sd_receiver.sv */
// sd spi response receiver
// hunts miso for the first zero bit, shifts in the r1 or data-response
// byte and, after a write, waits out the card busy period
`include "sd_consts.svh"

module sd_receiver (
  input  logic            clock,
  input  logic            reset,
  input  logic            bit_tick,
  input  logic            arm,
  input  logic            expect_data,
  input  logic            miso,
  output logic            rx_done,
  output sd_cmd_pkg::r1_t rx_byte,
  output logic            rx_timeout,
  output logic            busy_timeout
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_HUNT,
    RX_SHIFT,
    RX_BUSY
  } rx_state_e;

  localparam int CNT_BITS   = $clog2(`SD_BUSY_TIMEOUT + 1);
  localparam int HUNT_TICKS = `SD_RESP_WAIT_BYTES * 8;

  rx_state_e state;
  // ticks while hunting or busy, bits while shifting
  logic [CNT_BITS-1:0] cnt;
  logic expect_q;
  logic take_bit;

  assign take_bit = bit_tick &&
                    ((state == RX_SHIFT) || ((state == RX_HUNT) && !miso));

  always_ff @(posedge clock) begin
    if (arm) begin
      rx_byte <= 8'hFF;
    end else if (take_bit) begin
      rx_byte <= {rx_byte[6:0], miso};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= RX_IDLE;
      cnt          <= '0;
      expect_q     <= 1'b0;
      rx_done      <= 1'b0;
      rx_timeout   <= 1'b0;
      busy_timeout <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (arm) begin
            state        <= RX_HUNT;
            cnt          <= '0;
            expect_q     <= expect_data;
            rx_timeout   <= 1'b0;
            busy_timeout <= 1'b0;
          end
        end
        RX_HUNT: begin
          if (bit_tick) begin
            if (!miso) begin
              // the zero is the first bit of the byte
              state <= RX_SHIFT;
              cnt   <= CNT_BITS'(1);
            end else if (cnt == CNT_BITS'(HUNT_TICKS - 1)) begin
              state      <= RX_IDLE;
              rx_done    <= 1'b1;
              rx_timeout <= 1'b1;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        RX_SHIFT: begin
          if (bit_tick) begin
            if (cnt == CNT_BITS'(7)) begin
              cnt <= '0;
              if (expect_q) begin
                state <= RX_BUSY;
              end else begin
                state   <= RX_IDLE;
                rx_done <= 1'b1;
              end
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        RX_BUSY: begin
          if (bit_tick) begin
            if (miso) begin
              state   <= RX_IDLE;
              rx_done <= 1'b1;
            end else if (cnt == CNT_BITS'(`SD_BUSY_TIMEOUT - 1)) begin
              state        <= RX_IDLE;
              rx_done      <= 1'b1;
              busy_timeout <= 1'b1;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

/* design/sd_spi_top.sv */
// sd spi command and write engine
// host request queue with credit return, sequencer, frame sender and
// response receiver on a plain four wire spi link
`include "sd_consts.svh"

module sd_spi_top (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      req_valid,
  input  sd_cmd_pkg::req_kind_e     req_kind,
  input  sd_cmd_pkg::cmd_index_t    req_index,
  input  sd_cmd_pkg::cmd_arg_t      req_arg,
  input  logic [`SD_BLOCK_BITS-1:0] req_data,
  output logic                      credit_return,
  output logic                      done_valid,
  output sd_ctrl_pkg::done_status_e done_status,
  output sd_cmd_pkg::r1_t           done_resp,
  input  logic                      cfg_div_write,
  input  logic [`SD_DIV_BITS-1:0]   cfg_div_value,
  output logic                      sclk,
  output logic                      cs_n,
  output logic                      mosi,
  input  logic                      miso
);

  logic [`SD_DIV_BITS-1:0] cfg_div;
  logic head_valid;
  sd_cmd_pkg::req_kind_e head_kind;
  sd_cmd_pkg::cmd_index_t head_index;
  sd_cmd_pkg::cmd_arg_t head_arg;
  logic [`SD_BLOCK_BITS-1:0] head_data;
  logic pop;
  logic load;
  sd_cmd_pkg::req_kind_e ld_kind;
  sd_cmd_pkg::cmd_index_t ld_index;
  sd_cmd_pkg::cmd_arg_t ld_arg;
  logic [`SD_BLOCK_BITS-1:0] ld_data;
  logic bit_tick;
  logic sending;
  logic arm;
  logic expect_data;
  logic rx_done;
  sd_cmd_pkg::r1_t rx_byte;
  logic rx_timeout;
  logic busy_timeout;

  sd_ctrl_regs u_regs (
    .clock         (clock),
    .reset         (reset),
    .cfg_div_write (cfg_div_write),
    .cfg_div_value (cfg_div_value),
    .cfg_div       (cfg_div),
    .req_valid     (req_valid),
    .req_kind      (req_kind),
    .req_index     (req_index),
    .req_arg       (req_arg),
    .req_data      (req_data),
    .head_valid    (head_valid),
    .head_kind     (head_kind),
    .head_index    (head_index),
    .head_arg      (head_arg),
    .head_data     (head_data),
    .pop           (pop),
    .credit_return (credit_return)
  );

  sd_controller u_ctrl (
    .clock        (clock),
    .reset        (reset),
    .cfg_div      (cfg_div),
    .head_valid   (head_valid),
    .head_kind    (head_kind),
    .head_index   (head_index),
    .head_arg     (head_arg),
    .head_data    (head_data),
    .pop          (pop),
    .load         (load),
    .kind         (ld_kind),
    .index        (ld_index),
    .arg          (ld_arg),
    .data         (ld_data),
    .bit_tick     (bit_tick),
    .sclk         (sclk),
    .cs_n         (cs_n),
    .sending      (sending),
    .arm          (arm),
    .expect_data  (expect_data),
    .rx_done      (rx_done),
    .rx_byte      (rx_byte),
    .rx_timeout   (rx_timeout),
    .busy_timeout (busy_timeout),
    .done_valid   (done_valid),
    .done_status  (done_status),
    .done_resp    (done_resp)
  );

  sd_sender u_sender (
    .clock    (clock),
    .reset    (reset),
    .bit_tick (bit_tick),
    .load     (load),
    .kind     (ld_kind),
    .index    (ld_index),
    .arg      (ld_arg),
    .data     (ld_data),
    .mosi     (mosi),
    .sending  (sending)
  );

  sd_receiver u_receiver (
    .clock        (clock),
    .reset        (reset),
    .bit_tick     (bit_tick),
    .arm          (arm),
    .expect_data  (expect_data),
    .miso         (miso),
    .rx_done      (rx_done),
    .rx_byte      (rx_byte),
    .rx_timeout   (rx_timeout),
    .busy_timeout (busy_timeout)
  );

endmodule

/* tests/sd_card_model.sv */
// behavioural sd card on the spi bus
// checks the crc7 of a command and the crc16 of a data block, answers with
// an r1 byte or a data-response token, then holds busy after a write
`include "sd_consts.svh"

module sd_card_model (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  input  logic hold_busy_forever,
  output logic miso
);
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] {
    M_HUNT,
    M_CMD,
    M_DATA,
    M_REPLY
  } mode_e;

  mode_e mode;
  int ones;
  int bit_cnt;
  logic [`SD_CMD_BITS-1:0] frame;
  logic [15:0] crc16;
  logic [15:0] rx_crc16;
  logic busy_forever;
  logic out_q[$];

  // x^7 + x^3 + 1, one bit at a time
  function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic b);
    logic fb;
    fb = crc[6] ^ b;
    return {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
  endfunction

  // ccitt x^16 + x^12 + x^5 + 1
  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic b);
    logic fb;
    fb = crc[15] ^ b;
    return {crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
  endfunction

  task automatic queue_byte(input sd_cmd_pkg::r1_t value);
    int i;
    for (i = 7; i >= 0; i--) begin
      out_q.push_back(value[i]);
    end
  endtask

  task automatic end_command();
    logic [6:0] crc;
    int i;
    crc = '0;
    for (i = `SD_CMD_BITS - 1; i >= 8; i--) begin
      crc = crc7_step(crc, frame[i]);
    end
    mode = M_REPLY;
    // cmd63 is left unanswered so the host sees a response timeout
    if (frame[45:40] != 6'd63) begin
      queue_byte(8'hFF);
      queue_byte((crc == frame[7:1] && frame[46] && frame[0]) ? 8'h00 : 8'h08);
    end
  endtask

  task automatic end_block();
    mode = M_REPLY;
    queue_byte(8'hFF);
    queue_byte((crc16 == rx_crc16) ? 8'h05 : 8'h0B);
    // sixteen bits of busy
    queue_byte(8'h00);
    queue_byte(8'h00);
    busy_forever = hold_busy_forever;
  endtask

  task automatic take_bit(input logic b);
    case (mode)
      M_HUNT: begin
        if (b) begin
          ones++;
        end else if (ones >= 4) begin
          // a data token brings seven ones ahead of its zero
          mode    = M_DATA;
          bit_cnt = 0;
          crc16   = '0;
        end else begin
          mode    = M_CMD;
          frame   = '0;
          bit_cnt = 1;
        end
      end
      M_CMD: begin
        frame = {frame[`SD_CMD_BITS-2:0], b};
        bit_cnt++;
        if (bit_cnt == `SD_CMD_BITS) begin
          end_command();
        end
      end
      M_DATA: begin
        if (bit_cnt < `SD_BLOCK_BITS) begin
          crc16 = crc16_step(crc16, b);
        end else begin
          rx_crc16 = {rx_crc16[14:0], b};
        end
        bit_cnt++;
        if (bit_cnt == `SD_BLOCK_BITS + 16) begin
          end_block();
        end
      end
      default: ;
    endcase
  endtask

  initial begin
    miso         = 1'b1;
    mode         = M_HUNT;
    ones         = 0;
    bit_cnt      = 0;
    busy_forever = 1'b0;
    forever begin
      @(posedge sclk or negedge sclk or posedge cs_n);
      if (cs_n) begin
        mode         = M_HUNT;
        ones         = 0;
        busy_forever = 1'b0;
        miso         = 1'b1;
        out_q.delete();
      end else if (sclk) begin
        take_bit(mosi);
      end else begin
        // miso moves a little after the falling edge
        #1;
        if (out_q.size() != 0) begin
          miso = out_q.pop_front();
        end else begin
          miso = !busy_forever;
        end
      end
    end
  end

endmodule

/* tests/sd_spi_tb.sv */
// testbench for the sd spi command and write engine
// directed tests for commands, block writes, timeouts, back to back
// requests and the spi clock divider, against a behavioural card
`include "sd_consts.svh"

module sd_spi_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DONE_TIMEOUT = 40000;
  localparam int EDGE_TIMEOUT = 64;
  localparam int DRIVE_DELAY  = 2;

  logic clock;
  logic reset;
  logic req_valid;
  sd_cmd_pkg::req_kind_e req_kind;
  sd_cmd_pkg::cmd_index_t req_index;
  sd_cmd_pkg::cmd_arg_t req_arg;
  logic [`SD_BLOCK_BITS-1:0] req_data;
  logic credit_return;
  logic done_valid;
  sd_ctrl_pkg::done_status_e done_status;
  sd_cmd_pkg::r1_t done_resp;
  logic cfg_div_write;
  logic [`SD_DIV_BITS-1:0] cfg_div_value;
  logic sclk;
  logic cs_n;
  logic mosi;
  logic miso;
  logic hold_busy_forever;

  int issued;
  int credit_returns;
  int checks;
  int value_errors;
  int other_errors;
  logic [31:0] lfsr;
  sd_ctrl_pkg::done_status_e status_q[$];
  sd_cmd_pkg::r1_t resp_q[$];

  sd_spi_top DUT (
    .clock         (clock),
    .reset         (reset),
    .req_valid     (req_valid),
    .req_kind      (req_kind),
    .req_index     (req_index),
    .req_arg       (req_arg),
    .req_data      (req_data),
    .credit_return (credit_return),
    .done_valid    (done_valid),
    .done_status   (done_status),
    .done_resp     (done_resp),
    .cfg_div_write (cfg_div_write),
    .cfg_div_value (cfg_div_value),
    .sclk          (sclk),
    .cs_n          (cs_n),
    .mosi          (mosi),
    .miso          (miso)
  );

  sd_card_model card (
    .sclk              (sclk),
    .cs_n              (cs_n),
    .mosi              (mosi),
    .hold_busy_forever (hold_busy_forever),
    .miso              (miso)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // credits and completions are sampled on the clock edge
  always @(posedge clock) begin
    if (!reset) begin
      if (credit_return) begin
        credit_returns++;
      end
      if (done_valid) begin
        status_q.push_back(done_status);
        resp_q.push_back(done_resp);
      end
    end
  end

  function automatic int credits_held();
    return `SD_REQ_DEPTH - issued + credit_returns;
  endfunction

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [`SD_BLOCK_BITS-1:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      bits = {bits[`SD_BLOCK_BITS-2:0], lfsr[0]};
    end
  endtask

  task automatic step();
    @(posedge clock);
    #DRIVE_DELAY;
  endtask

  task automatic check_status(input string name, input sd_ctrl_pkg::done_status_e got,
                              input sd_ctrl_pkg::done_status_e exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input sd_cmd_pkg::r1_t got,
                            input sd_cmd_pkg::r1_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_credits(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      value_errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      value_errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic write_divider(input logic [`SD_DIV_BITS-1:0] value);
    cfg_div_write = 1'b1;
    cfg_div_value = value;
    step();
    cfg_div_write = 1'b0;
  endtask

  task automatic issue_request(input sd_cmd_pkg::req_kind_e kind,
                               input sd_cmd_pkg::cmd_index_t index,
                               input sd_cmd_pkg::cmd_arg_t arg,
                               input logic [`SD_BLOCK_BITS-1:0] data);
    if (credits_held() <= 0) begin
      other_errors++;
      $display("host tried to issue a request without holding a credit");
    end
    req_valid = 1'b1;
    req_kind  = kind;
    req_index = index;
    req_arg   = arg;
    req_data  = data;
    issued++;
    step();
    req_valid = 1'b0;
  endtask

  task automatic wait_done(output sd_ctrl_pkg::done_status_e status,
                           output sd_cmd_pkg::r1_t resp);
    int cycles;
    cycles = 0;
    while (status_q.size() == 0 && cycles < DONE_TIMEOUT) begin
      step();
      cycles++;
    end
    if (status_q.size() == 0) begin
      other_errors++;
      $display("no completion from the engine within %0d cycles", DONE_TIMEOUT);
      status = sd_ctrl_pkg::done_status_e'(2'b11);
      resp   = 'x;
    end else begin
      status = status_q.pop_front();
      resp   = resp_q.pop_front();
    end
  endtask

  // clocks from one rising sclk edge to the next
  task automatic measure_sclk_period(output int period);
    logic prev;
    int cycles;
    logic found;
    period = 0;
    found  = 1'b0;
    cycles = 0;
    prev   = sclk;
    while (!found && cycles < EDGE_TIMEOUT) begin
      step();
      cycles++;
      found = !prev && sclk;
      prev  = sclk;
    end
    if (!found) begin
      other_errors++;
      $display("sclk never rose while the engine was busy");
    end else begin
      found = 1'b0;
      while (!found && period < EDGE_TIMEOUT) begin
        step();
        period++;
        found = !prev && sclk;
        prev  = sclk;
      end
      if (!found) begin
        other_errors++;
        $display("sclk did not rise a second time");
      end
    end
  endtask

  task automatic test_reset_state();
    int i;
    for (i = 0; i < 8; i++) begin
      step();
      check_level("cs_n", cs_n, 1'b1);
      check_level("credit_return", credit_return, 1'b0);
      check_level("done_valid", done_valid, 1'b0);
      check_level("mosi", mosi, 1'b1);
    end
    check_credits("host credits", credits_held(), `SD_REQ_DEPTH);
  endtask

  task automatic test_command(input int div);
    logic [`SD_BLOCK_BITS-1:0] bits;
    sd_cmd_pkg::cmd_index_t index;
    sd_ctrl_pkg::done_status_e status;
    sd_cmd_pkg::r1_t resp;
    int period;
    write_divider(div[`SD_DIV_BITS-1:0]);
    take_bits(6, bits);
    // cmd63 is the silent one
    index = (bits[5:0] == 6'd63) ? 6'd0 : bits[5:0];
    take_bits(32, bits);
    issue_request(sd_cmd_pkg::REQ_CMD, index, bits[31:0], '0);
    measure_sclk_period(period);
    check_cycles("sclk period", period, div);
    wait_done(status, resp);
    check_status("done_status", status, sd_ctrl_pkg::ST_OK);
    check_resp("done_resp", resp, 8'h00);
    check_credits("host credits", credits_held(), `SD_REQ_DEPTH);
  endtask

  task automatic test_block_write();
    logic [`SD_BLOCK_BITS-1:0] bits;
    sd_ctrl_pkg::done_status_e status;
    sd_cmd_pkg::r1_t resp;
    write_divider(2);
    take_bits(`SD_BLOCK_BITS, bits);
    issue_request(sd_cmd_pkg::REQ_WRITE, 6'd24, 32'h0, bits);
    wait_done(status, resp);
    check_status("done_status", status, sd_ctrl_pkg::ST_OK);
    check_resp("done_resp", resp, 8'h05);
    check_credits("host credits", credits_held(), `SD_REQ_DEPTH);
  endtask

  task automatic test_timeouts();
    logic [`SD_BLOCK_BITS-1:0] bits;
    sd_ctrl_pkg::done_status_e status;
    sd_cmd_pkg::r1_t resp;
    take_bits(32, bits);
    issue_request(sd_cmd_pkg::REQ_CMD, 6'd63, bits[31:0], '0);
    wait_done(status, resp);
    check_status("done_status", status, sd_ctrl_pkg::ST_RESP_TIMEOUT);
    hold_busy_forever = 1'b1;
    take_bits(`SD_BLOCK_BITS, bits);
    issue_request(sd_cmd_pkg::REQ_WRITE, 6'd24, 32'h200, bits);
    wait_done(status, resp);
    hold_busy_forever = 1'b0;
    check_status("done_status", status, sd_ctrl_pkg::ST_BUSY_TIMEOUT);
    check_resp("done_resp", resp, 8'h05);
    check_credits("host credits", credits_held(), `SD_REQ_DEPTH);
  endtask

  task automatic test_back_to_back();
    logic [`SD_BLOCK_BITS-1:0] bits;
    sd_ctrl_pkg::done_status_e status;
    sd_cmd_pkg::r1_t resp;
    int returns_before;
    returns_before = credit_returns;
    take_bits(32, bits);
    issue_request(sd_cmd_pkg::REQ_CMD, 6'd13, bits[31:0], '0);
    take_bits(`SD_BLOCK_BITS, bits);
    issue_request(sd_cmd_pkg::REQ_WRITE, 6'd24, 32'h400, bits);
    // the command answers 0x00 and the write 0x05, so order shows in the resp
    wait_done(status, resp);
    check_status("first done_status", status, sd_ctrl_pkg::ST_OK);
    check_resp("first done_resp", resp, 8'h00);
    wait_done(status, resp);
    check_status("second done_status", status, sd_ctrl_pkg::ST_OK);
    check_resp("second done_resp", resp, 8'h05);
    check_credits("credits returned", credit_returns - returns_before, 2);
    check_credits("host credits", credits_held(), `SD_REQ_DEPTH);
  endtask

  initial begin
    reset             = 1'b1;
    req_valid         = 1'b0;
    req_kind          = sd_cmd_pkg::REQ_CMD;
    req_index         = '0;
    req_arg           = '0;
    req_data          = '0;
    cfg_div_write     = 1'b0;
    cfg_div_value     = '0;
    hold_busy_forever = 1'b0;
    issued            = 0;
    credit_returns    = 0;
    checks            = 0;
    value_errors      = 0;
    other_errors      = 0;
    lfsr              = 32'h2a3a_6f24;
    repeat (10) @(posedge clock);
    #DRIVE_DELAY;
    reset = 1'b0;

    test_reset_state();
    test_command(2);
    test_block_write();
    test_timeouts();
    test_back_to_back();
    test_command(5);

    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+design
design/sd_cmd_pkg.sv
design/sd_ctrl_pkg.sv
design/sd_ctrl_regs.sv
design/sd_controller.sv
design/sd_sender.sv
design/sd_receiver.sv
design/sd_spi_top.sv
tests/sd_card_model.sv
tests/sd_spi_tb.sv
